// File: rtl/alu_pkg.sv
package alu_pkg;

    // Operation codes shared by both execution units
    // ADD sits at zero so a cleared op register decodes as ADD
    typedef enum logic [5:0] {
        // Adder and logic
        ADD = 6'd0,
        SUB,
        SH1ADD,
        SH2ADD,
        SH3ADD,
        AND,
        OR,
        XOR,
        ANDN,
        ORN,
        XNOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set and branch compares
        SLT,
        SLTU,
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Min/max and conditional zero
        MIN,
        MAX,
        MINU,
        MAXU,
        CZERO_EQZ,
        CZERO_NEZ,
        // Bit-manipulation unit
        CLZ,
        CTZ,
        CPOP,
        SEXTB,
        SEXTH,
        ZEXTH,
        ROL,
        ROR,
        ORCB,
        REV8,
        BCLR,
        BEXT,
        BINV,
        BSET
    } alu_op_e;

    // True for operations served by the bit-manipulation unit
    function automatic logic op_is_bitmanip(alu_op_e op);
        logic is_bm;
        case (op)
            CLZ, CTZ, CPOP,
            SEXTB, SEXTH, ZEXTH,
            ROL, ROR, ORCB, REV8,
            BCLR, BEXT, BINV, BSET: is_bm = 1'b1;
            default:                is_bm = 1'b0;
        endcase
        return is_bm;
    endfunction

endpackage

// File: rtl/alu_lzc.sv
`timescale 1ns/1ps

module alu_lzc #(
    parameter int unsigned WIDTH = 64
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    localparam int unsigned CW = $clog2(WIDTH);

    // Heap-ordered tree with children 2n+1 (upper half) and 2n+2 under node n
    // Leaves start at WIDTH-1
    // Leaf j holds input bit WIDTH-1-j
    // WIDTH is expected to be a power of two
    logic          vld_nodes [2*WIDTH-1];
    logic [CW-1:0] cnt_nodes [2*WIDTH-1];

    // ------------------------------------------------------------------------
    // Leaves
    // ------------------------------------------------------------------------
    for (genvar j = 0; j < WIDTH; j++) begin : gen_leaves
        assign vld_nodes[WIDTH-1+j] = in_i[WIDTH-1-j];
        assign cnt_nodes[WIDTH-1+j] = CW'(j);
    end

    // ------------------------------------------------------------------------
    // Reduction
    // ------------------------------------------------------------------------
    // Upper half wins whenever it holds a set bit
    for (genvar n = 0; n < WIDTH-1; n++) begin : gen_nodes
        assign vld_nodes[n] = vld_nodes[2*n+1] | vld_nodes[2*n+2];
        assign cnt_nodes[n] = vld_nodes[2*n+1] ? cnt_nodes[2*n+1] : cnt_nodes[2*n+2];
    end

    assign cnt_o   = cnt_nodes[0];
    assign empty_o = ~vld_nodes[0];

endmodule

// File: rtl/alu_arith.sv
`timescale 1ns/1ps

module alu_arith #(
    parameter int unsigned XLEN = 64
) (
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    output logic [XLEN-1:0]  result_o,
    output logic             branch_o
);

    localparam int unsigned SHW = $clog2(XLEN);

    logic            negate_b;
    logic [XLEN-1:0] adder_a;
    logic [XLEN:0]   operand_b_neg;
    logic [XLEN:0]   adder_sum;
    logic [XLEN-1:0] adder_result;
    logic            adder_zero;

    logic            cmp_signed;
    logic            less;

    logic [SHW-1:0]  shamt;
    logic            shift_left;
    logic            shift_arith;
    logic [XLEN-1:0] operand_a_rev;
    logic [XLEN-1:0] shift_in;
    logic [XLEN:0]   shift_ext;
    logic [XLEN:0]   shift_right_ext;
    logic [XLEN-1:0] shift_left_res;
    logic [XLEN-1:0] shift_result;

    // ------------------------------------------------------------------------
    // Adder
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            alu_pkg::SUB, alu_pkg::EQ, alu_pkg::NE,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: negate_b = 1'b1;
            default:                                    negate_b = 1'b0;
        endcase
    end

    // Pre-shift of operand a for the shift-add forms
    always_comb begin
        case (op_i)
            alu_pkg::SH1ADD: adder_a = operand_a_i << 1;
            alu_pkg::SH2ADD: adder_a = operand_a_i << 2;
            alu_pkg::SH3ADD: adder_a = operand_a_i << 3;
            default:         adder_a = operand_a_i;
        endcase
    end

    // Extra low bit carries the +1 of the two's complement negation
    assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum     = {adder_a, 1'b1} + operand_b_neg;
    assign adder_result  = adder_sum[XLEN:1];
    assign adder_zero    = ~|adder_result;

    // ------------------------------------------------------------------------
    // Comparator
    // ------------------------------------------------------------------------
    assign cmp_signed = (op_i == alu_pkg::SLT) || (op_i == alu_pkg::LTS) ||
                        (op_i == alu_pkg::GES) || (op_i == alu_pkg::MIN) ||
                        (op_i == alu_pkg::MAX);

    assign less = $signed({cmp_signed & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({cmp_signed & operand_b_i[XLEN-1], operand_b_i});

    // ------------------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------------------
    assign shamt       = operand_b_i[SHW-1:0];
    assign shift_left  = (op_i == alu_pkg::SLL);
    assign shift_arith = (op_i == alu_pkg::SRA);

    // Left shifts run through the right shifter on bit-reversed data
    for (genvar i = 0; i < XLEN; i++) begin : gen_rev
        assign operand_a_rev[i]  = operand_a_i[XLEN-1-i];
        assign shift_left_res[i] = shift_right_ext[XLEN-1-i];
    end

    assign shift_in        = shift_left ? operand_a_rev : operand_a_i;
    assign shift_ext       = {shift_arith & shift_in[XLEN-1], shift_in};
    assign shift_right_ext = $unsigned($signed(shift_ext) >>> shamt);
    assign shift_result    = shift_left ? shift_left_res : shift_right_ext[XLEN-1:0];

    // ------------------------------------------------------------------------
    // Result and branch
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            alu_pkg::ADD, alu_pkg::SUB,
            alu_pkg::SH1ADD, alu_pkg::SH2ADD,
            alu_pkg::SH3ADD:                 result_o = adder_result;
            alu_pkg::AND, alu_pkg::ANDN:     result_o = operand_a_i & operand_b_neg[XLEN:1];
            alu_pkg::OR, alu_pkg::ORN:       result_o = operand_a_i | operand_b_neg[XLEN:1];
            alu_pkg::XOR, alu_pkg::XNOR:     result_o = operand_a_i ^ operand_b_neg[XLEN:1];
            alu_pkg::SLL, alu_pkg::SRL,
            alu_pkg::SRA:                    result_o = shift_result;
            alu_pkg::SLT, alu_pkg::SLTU:     result_o = {{(XLEN-1){1'b0}}, less};
            alu_pkg::MIN, alu_pkg::MINU:     result_o = less ? operand_a_i : operand_b_i;
            alu_pkg::MAX, alu_pkg::MAXU:     result_o = less ? operand_b_i : operand_a_i;
            alu_pkg::CZERO_EQZ:              result_o = (|operand_b_i) ? operand_a_i : '0;
            alu_pkg::CZERO_NEZ:              result_o = (|operand_b_i) ? '0 : operand_a_i;
            default:                         result_o = '0;
        endcase
    end

    // Non-branch operations report taken
    always_comb begin
        case (op_i)
            alu_pkg::EQ:                branch_o = adder_zero;
            alu_pkg::NE:                branch_o = ~adder_zero;
            alu_pkg::LTS, alu_pkg::LTU: branch_o = less;
            alu_pkg::GES, alu_pkg::GEU: branch_o = ~less;
            default:                    branch_o = 1'b1;
        endcase
    end

endmodule

// File: rtl/alu_bitmanip.sv
`timescale 1ns/1ps

module alu_bitmanip #(
    parameter int unsigned XLEN = 64
) (
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    output logic [XLEN-1:0]  result_o
);

    localparam int unsigned SHW    = $clog2(XLEN);
    localparam int unsigned NBYTES = XLEN / 8;

    logic [XLEN-1:0] operand_a_rev;
    logic [XLEN-1:0] lzc_in;
    logic [SHW-1:0]  lzc_cnt;
    logic            lzc_empty;
    logic [XLEN-1:0] zero_cnt;

    logic [SHW:0]    pop_nodes [2*XLEN-1];

    logic [SHW-1:0]  amt;
    logic [SHW-1:0]  amt_neg;
    logic [XLEN-1:0] rol_res;
    logic [XLEN-1:0] ror_res;
    logic [XLEN-1:0] orcb_res;
    logic [XLEN-1:0] rev8_res;
    logic [XLEN-1:0] bit_mask;

    // ------------------------------------------------------------------------
    // Leading and trailing zeros
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < XLEN; i++) begin : gen_rev
        assign operand_a_rev[i] = operand_a_i[XLEN-1-i];
    end

    // Trailing zeros of a are the leading zeros of its reverse
    assign lzc_in = (op_i == alu_pkg::CTZ) ? operand_a_rev : operand_a_i;

    alu_lzc #(
        .WIDTH (XLEN)
    ) u_lzc (
        .in_i    (lzc_in),
        .cnt_o   (lzc_cnt),
        .empty_o (lzc_empty)
    );

    assign zero_cnt = lzc_empty ? XLEN'(XLEN) : XLEN'(lzc_cnt);

    // ------------------------------------------------------------------------
    // Population count
    // ------------------------------------------------------------------------
    // Same heap layout as the zero counter with each node adding its two children
    for (genvar j = 0; j < XLEN; j++) begin : gen_pop_leaves
        assign pop_nodes[XLEN-1+j] = (SHW+1)'(operand_a_i[j]);
    end

    for (genvar n = 0; n < XLEN-1; n++) begin : gen_pop_nodes
        assign pop_nodes[n] = pop_nodes[2*n+1] + pop_nodes[2*n+2];
    end

    // ------------------------------------------------------------------------
    // Permutations and single-bit masks
    // ------------------------------------------------------------------------
    assign amt     = operand_b_i[SHW-1:0];
    // Complementary amount modulo XLEN where zero stays zero
    assign amt_neg = -amt;
    assign rol_res = (operand_a_i << amt) | (operand_a_i >> amt_neg);
    assign ror_res = (operand_a_i >> amt) | (operand_a_i << amt_neg);

    for (genvar g = 0; g < NBYTES; g++) begin : gen_bytes
        assign orcb_res[8*g +: 8] = {8{|operand_a_i[8*g +: 8]}};
        assign rev8_res[8*g +: 8] = operand_a_i[8*(NBYTES-1-g) +: 8];
    end

    assign bit_mask = {{(XLEN-1){1'b0}}, 1'b1} << amt;

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            alu_pkg::CLZ, alu_pkg::CTZ: result_o = zero_cnt;
            alu_pkg::CPOP:  result_o = {{(XLEN-SHW-1){1'b0}}, pop_nodes[0]};
            alu_pkg::SEXTB: result_o = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
            alu_pkg::SEXTH: result_o = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
            alu_pkg::ZEXTH: result_o = {{(XLEN-16){1'b0}}, operand_a_i[15:0]};
            alu_pkg::ROL:   result_o = rol_res;
            alu_pkg::ROR:   result_o = ror_res;
            alu_pkg::ORCB:  result_o = orcb_res;
            alu_pkg::REV8:  result_o = rev8_res;
            alu_pkg::BCLR:  result_o = operand_a_i & ~bit_mask;
            alu_pkg::BEXT:  result_o = {{(XLEN-1){1'b0}}, |(operand_a_i & bit_mask)};
            alu_pkg::BINV:  result_o = operand_a_i ^ bit_mask;
            alu_pkg::BSET:  result_o = operand_a_i | bit_mask;
            default:        result_o = '0;
        endcase
    end

endmodule

// File: rtl/alu_writeback.sv
`timescale 1ns/1ps

module alu_writeback #(
    parameter int unsigned XLEN = 64
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             req_i,
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  arith_result_i,
    input  logic [XLEN-1:0]  bm_result_i,
    input  logic             branch_i,
    output logic [XLEN-1:0]  result_o,
    output logic             branch_o,
    output logic             ack_o
);

    logic [XLEN-1:0] result_sel;

    // Pick the unit that owns this operation
    assign result_sel = alu_pkg::op_is_bitmanip(op_i) ? bm_result_i : arith_result_i;

    // ------------------------------------------------------------------------
    // Result registers
    // ------------------------------------------------------------------------
    // Held until the next start and across the ack falling edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
            branch_o <= 1'b0;
        end else if (start_i) begin
            result_o <= result_sel;
            branch_o <= branch_i;
        end
    end

    // ------------------------------------------------------------------------
    // Four-phase ack
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else if (start_i) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            // Requester has released so the handshake closes
            ack_o <= 1'b0;
        end
    end

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int unsigned XLEN = 64
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             req_i,
    input  alu_pkg::alu_op_e op_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    output logic             ack_o,
    output logic [XLEN-1:0]  result_o,
    output logic             branch_o
);

    logic             capture_en;
    logic             start_q;
    alu_pkg::alu_op_e op_q;
    logic [XLEN-1:0]  operand_a_q;
    logic [XLEN-1:0]  operand_b_q;

    logic [XLEN-1:0]  arith_result;
    logic             branch_res;
    logic [XLEN-1:0]  bm_result;

    // ------------------------------------------------------------------------
    // Request capture
    // ------------------------------------------------------------------------
    // Start blocks a second capture in the cycle before ack rises
    assign capture_en = req_i & ~ack_o & ~start_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q     <= 1'b0;
            op_q        <= alu_pkg::ADD;
            operand_a_q <= '0;
            operand_b_q <= '0;
        end else begin
            start_q <= capture_en;
            if (capture_en) begin
                op_q        <= op_i;
                operand_a_q <= operand_a_i;
                operand_b_q <= operand_b_i;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Execution units and writeback
    // ------------------------------------------------------------------------
    alu_arith #(
        .XLEN (XLEN)
    ) u_arith (
        .op_i        (op_q),
        .operand_a_i (operand_a_q),
        .operand_b_i (operand_b_q),
        .result_o    (arith_result),
        .branch_o    (branch_res)
    );

    alu_bitmanip #(
        .XLEN (XLEN)
    ) u_bitmanip (
        .op_i        (op_q),
        .operand_a_i (operand_a_q),
        .operand_b_i (operand_b_q),
        .result_o    (bm_result)
    );

    alu_writeback #(
        .XLEN (XLEN)
    ) u_writeback (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (start_q),
        .req_i          (req_i),
        .op_i           (op_q),
        .arith_result_i (arith_result),
        .bm_result_i    (bm_result),
        .branch_i       (branch_res),
        .result_o       (result_o),
        .branch_o       (branch_o),
        .ack_o          (ack_o)
    );

endmodule

// File: test/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Expected result and branch bit from the instruction definitions
// Relies on XLEN and SHW of the including module
function automatic void alu_model(
    input  alu_pkg::alu_op_e op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic [XLEN-1:0]  res,
    output logic             br
);
    int unsigned sh;
    int          i;
    sh  = int'(b[SHW-1:0]);
    res = '0;
    br  = 1'b1;
    case (op)
        alu_pkg::ADD:       res = a + b;
        alu_pkg::SUB:       res = a - b;
        alu_pkg::SH1ADD:    res = a * 2 + b;
        alu_pkg::SH2ADD:    res = a * 4 + b;
        alu_pkg::SH3ADD:    res = a * 8 + b;
        alu_pkg::AND:       res = a & b;
        alu_pkg::OR:        res = a | b;
        alu_pkg::XOR:       res = a ^ b;
        alu_pkg::ANDN:      res = a & ~b;
        alu_pkg::ORN:       res = a | ~b;
        alu_pkg::XNOR:      res = ~(a ^ b);
        alu_pkg::SLL:       res = a << sh;
        alu_pkg::SRL:       res = a >> sh;
        alu_pkg::SRA:       res = $signed(a) >>> sh;
        alu_pkg::SLT:       res = XLEN'($signed(a) < $signed(b));
        alu_pkg::SLTU:      res = XLEN'(a < b);
        alu_pkg::EQ:        br = (a == b);
        alu_pkg::NE:        br = (a != b);
        alu_pkg::LTS:       br = ($signed(a) < $signed(b));
        alu_pkg::LTU:       br = (a < b);
        alu_pkg::GES:       br = ($signed(a) >= $signed(b));
        alu_pkg::GEU:       br = (a >= b);
        alu_pkg::MIN:       res = ($signed(a) <= $signed(b)) ? a : b;
        alu_pkg::MAX:       res = ($signed(a) >= $signed(b)) ? a : b;
        alu_pkg::MINU:      res = (a <= b) ? a : b;
        alu_pkg::MAXU:      res = (a >= b) ? a : b;
        alu_pkg::CZERO_EQZ: res = (b == '0) ? '0 : a;
        alu_pkg::CZERO_NEZ: res = (b != '0) ? '0 : a;
        alu_pkg::CLZ: begin
            res = XLEN'(XLEN);
            // Highest set bit is the last one found
            for (i = 0; i < XLEN; i++) if (a[i]) res = XLEN'(XLEN - 1 - i);
        end
        alu_pkg::CTZ: begin
            res = XLEN'(XLEN);
            for (i = XLEN - 1; i >= 0; i--) if (a[i]) res = XLEN'(i);
        end
        alu_pkg::CPOP:      for (i = 0; i < XLEN; i++) res = res + XLEN'(a[i]);
        alu_pkg::SEXTB:     res = XLEN'($signed(a[7:0]));
        alu_pkg::SEXTH:     res = XLEN'($signed(a[15:0]));
        alu_pkg::ZEXTH:     res = XLEN'(a[15:0]);
        alu_pkg::ROL:       for (i = 0; i < XLEN; i++) res[(i + sh) % XLEN] = a[i];
        alu_pkg::ROR:       for (i = 0; i < XLEN; i++) res[i] = a[(i + sh) % XLEN];
        alu_pkg::ORCB: begin
            for (i = 0; i < XLEN / 8; i++) begin
                res[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
            end
        end
        alu_pkg::REV8: begin
            for (i = 0; i < XLEN / 8; i++) begin
                res[8*i +: 8] = a[XLEN-8-8*i +: 8];
            end
        end
        alu_pkg::BCLR: begin
            res     = a;
            res[sh] = 1'b0;
        end
        alu_pkg::BEXT:      res = XLEN'(a[sh]);
        alu_pkg::BINV: begin
            res     = a;
            res[sh] = ~a[sh];
        end
        alu_pkg::BSET: begin
            res     = a;
            res[sh] = 1'b1;
        end
        default:            res = '0;
    endcase
endfunction

`endif

// File: test/tb_alu_unit.sv
`timescale 1ns/1ps

module tb_alu_unit;

    localparam int unsigned XLEN         = 64;
    localparam int unsigned SHW          = $clog2(XLEN);
    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam int          HOLD_CYCLES  = 5;
    localparam int          N_EDGES      = 6;
    localparam int          N_RANDOM     = 200;
    localparam int          N_SIGN       = 20;
    localparam int          N_OPS        = int'(alu_pkg::BSET) + 1;
    localparam int          N_CMP        = int'(alu_pkg::CZERO_NEZ) - int'(alu_pkg::SLT) + 1;
    localparam int          NUM_VECTORS  = N_EDGES * N_EDGES * N_OPS + N_RANDOM * N_OPS +
                                           N_SIGN * 2 * N_CMP + 4;
    localparam int          TIMEOUT_NS   = NUM_VECTORS * 8 * CLK_PERIOD +
                                           RESET_CYCLES * CLK_PERIOD;

    localparam logic [XLEN-1:0] SIGN_BIT = {1'b1, {(XLEN-1){1'b0}}};
    // Zero, all ones, sign bit alone, one, largest shift amount, byte pattern
    localparam logic [XLEN-1:0] EDGE_VALS [N_EDGES] = '{
        {XLEN{1'b0}}, {XLEN{1'b1}}, SIGN_BIT, XLEN'(1), XLEN'(XLEN-1),
        XLEN'(64'h0123_4567_89ab_cdef)
    };

    logic             clk_i;
    logic             rst_n_i;
    logic             req_i;
    alu_pkg::alu_op_e op_i;
    logic [XLEN-1:0]  operand_a_i;
    logic [XLEN-1:0]  operand_b_i;
    logic             ack_o;
    logic [XLEN-1:0]  result_o;
    logic             branch_o;

    integer          seed = 31;
    int              checks;
    int              result_errors;
    int              branch_errors;
    int              ack_errors;
    int              latency_errors;
    int              other_errors;
    logic            ack_seen = 1'b0;
    logic [XLEN-1:0] exp_res_q [$];
    logic            exp_br_q [$];
    string           name_q [$];

    `include "tb_alu_model.svh"

    alu_unit #(
        .XLEN (XLEN)
    ) dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            result_errors++;
            $display("error %s result: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_branch(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            branch_errors++;
            $display("error %s branch: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            ack_errors++;
            $display("error %s ack: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            latency_errors++;
            $display("error %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Compares each result in the cycle its ack rises
    always @(negedge clk_i) begin
        if (ack_o === 1'b1 && !ack_seen) begin
            if (name_q.size() == 0) begin
                other_errors++;
                $display("ack_o rose with no request outstanding");
            end else begin
                check_result(name_q[0], exp_res_q.pop_front(), result_o);
                check_branch(name_q[0], exp_br_q.pop_front(), branch_o);
                void'(name_q.pop_front());
            end
        end
        ack_seen = (ack_o === 1'b1);
    end

    // ------------------------------------------------------------------------
    // Handshake driver
    // ------------------------------------------------------------------------
    // Raises req and waits for ack, counting the rising edges in between
    task automatic start_op(input alu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        logic [XLEN-1:0] exp_res;
        logic            exp_br;
        string           name;
        int              edges;
        name = $sformatf("%s a=%h b=%h", op.name(), a, b);
        alu_model(op, a, b, exp_res, exp_br);
        exp_res_q.push_back(exp_res);
        exp_br_q.push_back(exp_br);
        name_q.push_back(name);
        @(negedge clk_i);
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        req_i       = 1'b1;
        edges       = 0;
        while (ack_o !== 1'b1) begin
            @(negedge clk_i);
            edges++;
        end
        check_latency(name, 2, edges);
    endtask

    task automatic finish_op();
        req_i = 1'b0;
        while (ack_o !== 1'b0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic run_op(input alu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
        start_op(op, a, b);
        finish_op();
    endtask

    // Requester keeps req high while it changes the operands
    task automatic hold_test(input alu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input alu_pkg::alu_op_e op_new,
                             input logic [XLEN-1:0] a_new, input logic [XLEN-1:0] b_new);
        logic [XLEN-1:0] held;
        logic            held_br;
        alu_model(op, a, b, held, held_br);
        start_op(op, a, b);
        repeat (HOLD_CYCLES) begin
            @(negedge clk_i);
            check_ack("hold", 1'b1, ack_o);
            check_result("hold", held, result_o);
            op_i        = op_new;
            operand_a_i = a_new;
            operand_b_i = b_new;
        end
        finish_op();
        check_result("hold after ack fell", held, result_o);
        run_op(op_new, a_new, b_new);
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return XLEN'({$random(seed), $random(seed)});
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              i;
        int              j;
        int              k;
        req_i       = 1'b0;
        op_i        = alu_pkg::ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        rst_n_i     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        check_ack("reset", 1'b0, ack_o);
        check_result("reset", '0, result_o);
        check_branch("reset", 1'b0, branch_o);

        // Every operation on every pair of edge values
        for (i = 0; i < N_EDGES; i++) begin
            for (j = 0; j < N_EDGES; j++) begin
                for (k = 0; k < N_OPS; k++) begin
                    run_op(alu_pkg::alu_op_e'(k), EDGE_VALS[i], EDGE_VALS[j]);
                end
            end
        end

        for (i = 0; i < N_RANDOM; i++) begin
            a = rand_word();
            b = rand_word();
            // Spread the leading zero counts
            if (i % 2 == 1) a = a >> ($unsigned($random(seed)) % XLEN);
            for (k = 0; k < N_OPS; k++) run_op(alu_pkg::alu_op_e'(k), a, b);
        end

        // Equal operands, and operands apart only in the sign bit
        for (i = 0; i < N_SIGN; i++) begin
            a = rand_word();
            for (k = int'(alu_pkg::SLT); k <= int'(alu_pkg::CZERO_NEZ); k++) begin
                run_op(alu_pkg::alu_op_e'(k), a, a);
                run_op(alu_pkg::alu_op_e'(k), a, a ^ SIGN_BIT);
            end
        end

        hold_test(alu_pkg::ADD, XLEN'(5), XLEN'(7), alu_pkg::SUB, XLEN'(100), XLEN'(1));

        if (name_q.size() != 0) begin
            other_errors++;
            $display("%0d results were never acknowledged", name_q.size());
        end
        $display("checks %0d, errors result %0d branch %0d ack %0d latency %0d other %0d",
                 checks, result_errors, branch_errors, ack_errors, latency_errors,
                 other_errors);
        if (result_errors + branch_errors + ack_errors + latency_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        #(TIMEOUT_NS);
        $display("handshake hung, ack_o did not change within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

// File: alu_unit.f
+incdir+test
rtl/alu_pkg.sv
rtl/alu_lzc.sv
rtl/alu_arith.sv
rtl/alu_bitmanip.sv
rtl/alu_writeback.sv
rtl/alu_unit.sv
test/tb_alu_unit.sv

// File: Makefile
# Verilator simulation of the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_unit
FILELIST  ?= alu_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
